// File: Bender.yml
package:
  name: mmc5_top

sources:
  - files:
      - hw/mmc5_reg_pkg.sv
      - hw/mmc5_bus_pkg.sv
      - hw/mmc5_regs.sv
      - hw/mmc5_prg_map.sv
      - hw/mmc5_chr_map.sv
      - hw/mmc5_exram.sv
      - hw/mmc5_scanline_irq.sv
      - hw/mmc5_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mmc5_tb.sv

// File: dv/mmc5_tb_vectors.svh
// MMC5 test table; expected values assume PRG_RAM_BASE 6'b111100, CHR ROM and the CHR region at 2'b10
`ifndef MMC5_TB_VECTORS_SVH
`define MMC5_TB_VECTORS_SVH

task automatic load_vectors();
	// Reset state, $E000 on ROM bank 7F
	cpu_check(16'hE000, 1'b0, SIG_PRG_ADDR, 22'h0FE000);
	cpu_check(16'hE000, 1'b0, SIG_IRQ, 22'h0);
	// RAM bank 3, ROM 05 and 0A, RAM 2, ROM 13
	cpu_write(16'h5113, 8'h03);
	cpu_write(16'h5114, 8'h85);
	cpu_write(16'h5115, 8'h8A);
	cpu_write(16'h5116, 8'h02);
	cpu_write(16'h5117, 8'h13);
	// Mode 3, four 8 KB windows
	cpu_check(16'h8123, 1'b0, SIG_PRG_ADDR, 22'h00A123);
	cpu_check(16'hA004, 1'b0, SIG_PRG_ADDR, 22'h014004);
	cpu_check(16'hC010, 1'b0, SIG_PRG_ADDR, 22'h3C4010);
	cpu_check(16'hE001, 1'b0, SIG_PRG_ADDR, 22'h026001);
	cpu_check(16'h6ABC, 1'b0, SIG_PRG_ADDR, 22'h3C6ABC); // Save RAM
	cpu_write(16'h5100, 8'h00); // Mode 0, 32 KB from bank 3
	cpu_check(16'h8000, 1'b0, SIG_PRG_ADDR, 22'h020000);
	cpu_check(16'hC000, 1'b0, SIG_PRG_ADDR, 22'h024000);
	cpu_write(16'h5100, 8'h01); // Mode 1
	cpu_check(16'hA000, 1'b0, SIG_PRG_ADDR, 22'h016000);
	cpu_check(16'hC000, 1'b0, SIG_PRG_ADDR, 22'h024000);
	cpu_write(16'h5100, 8'h02); // Mode 2
	cpu_check(16'h8000, 1'b0, SIG_PRG_ADDR, 22'h014000);
	cpu_check(16'hC000, 1'b0, SIG_PRG_ADDR, 22'h3C4000);
	cpu_check(16'hE000, 1'b0, SIG_PRG_ADDR, 22'h026000);
	// Protection, $C000 is RAM in mode 2
	cpu_check(16'hC000, 1'b1, SIG_PRG_ALLOW, 22'h0);
	cpu_check(16'hC000, 1'b0, SIG_PRG_ALLOW, 22'h1);
	cpu_check(16'h6000, 1'b1, SIG_PRG_ALLOW, 22'h0);
	cpu_write(16'h5102, 8'h02);
	cpu_write(16'h5103, 8'h01);
	cpu_check(16'h6000, 1'b1, SIG_PRG_ALLOW, 22'h1);
	cpu_check(16'hC000, 1'b1, SIG_PRG_ALLOW, 22'h1);
	cpu_check(16'hE000, 1'b1, SIG_PRG_ALLOW, 22'h0); // ROM
	// CHR banks, $5120 written last
	cpu_write(16'h5121, 8'h11);
	cpu_write(16'h5123, 8'h13);
	cpu_write(16'h5125, 8'h15);
	cpu_write(16'h5127, 8'h17);
	cpu_write(16'h5129, 8'h19);
	cpu_write(16'h512B, 8'h1B);
	cpu_write(16'h5120, 8'h10);
	ppu_step(14'h1C05, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h22FC05);
	cpu_write(16'h5101, 8'h01);
	ppu_step(14'h1405, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h217405);
	cpu_write(16'h5101, 8'h02);
	ppu_step(14'h1405, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h20AC05);
	cpu_write(16'h5101, 8'h03);
	ppu_step(14'h0405, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h204405);
	ppu_step(14'h1C05, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h205C05);
	cpu_write(16'h5128, 8'h18); // Second set now
	ppu_step(14'h1C05, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h206C05);
	ppu_step(14'h0405, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h206405);
	// 8x16 sprites, sprite fetch then background fetch
	ppu_step(14'h1C05, 1'b0, 8'h00, 1'b1, 1'b1, 9'd300, 9'd0, SIG_CHR_ADDR, 22'h205C05);
	cpu_write(16'h5120, 8'h10); // First set written last, background must still use set 1
	ppu_step(14'h1C05, 1'b0, 8'h00, 1'b1, 1'b1, 9'd100, 9'd0, SIG_CHR_ADDR, 22'h206C05);
	cpu_write(16'h5130, 8'h01); // Upper bits for the next bank write
	cpu_write(16'h512A, 8'h05);
	ppu_step(14'h0805, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ADDR, 22'h241405);
	// CHR ROM board, pattern writes stay blocked
	ppu_step(14'h0405, 1'b1, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_CHR_ALLOW, 22'h0);
	// Multiplier, 200 x 123
	cpu_write(16'h5205, 8'hC8);
	cpu_write(16'h5206, 8'h7B);
	cpu_read(16'h5205, 8'h18);
	cpu_read(16'h5206, 8'h60);
	cpu_read(16'h5000, 8'hFF);
	// ExRAM as CPU RAM
	cpu_write(16'h5104, 8'h02);
	cpu_write(16'h5C05, 8'hA5);
	cpu_write(16'h5FFF, 8'h3C);
	cpu_read(16'h5C05, 8'hA5);
	cpu_read(16'h5FFF, 8'h3C);
	cpu_write(16'h5104, 8'h03); // Read only
	cpu_write(16'h5C05, 8'h11);
	cpu_read(16'h5C05, 8'hA5);
	// Nametables, quadrants VRAM_A, VRAM_B, EXRAM, FILL
	cpu_write(16'h5104, 8'h00);
	cpu_write(16'h5105, 8'hE4);
	cpu_write(16'h5106, 8'h47);
	cpu_write(16'h5107, 8'h02);
	ppu_step(14'h2810, 1'b1, 8'h5A, 1'b0, 1'b0, 9'd0, 9'd0, SIG_NONE, 22'h0);
	ppu_step(14'h2810, 1'b0, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, SIG_CHR_RDATA, 22'h5A);
	ppu_step(14'h2810, 1'b0, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, SIG_NT, 22'h4);
	ppu_step(14'h2005, 1'b0, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, SIG_NT, 22'h1);
	ppu_step(14'h2405, 1'b0, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, SIG_NT, 22'h3);
	ppu_step(14'h2C05, 1'b0, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, SIG_CHR_RDATA, 22'h47);
	ppu_step(14'h2C05, 1'b0, 8'h00, 1'b1, 1'b0, 9'd2, 9'd0, SIG_CHR_RDATA, 22'hAA);
	ppu_step(14'h2C05, 1'b0, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, SIG_NT, 22'h6);
	// Scanline IRQ on line 20, enabled
	cpu_write(16'h5203, 8'h14);
	cpu_write(16'h5204, 8'h80);
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd19, SIG_IRQ, 22'h0);
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd20, SIG_IRQ, 22'h0);
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd21, SIG_IRQ, 22'h1);
	cpu_check(16'h5204, 1'b0, SIG_PRG_RDATA, 22'hBF);
	cpu_read(16'h5204, 8'h3F); // Read clears pending
	cpu_check(16'h5204, 1'b0, SIG_IRQ, 22'h0);
	cpu_write(16'h5203, 8'h00); // Line 0 never fires, even on scanline 0
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, SIG_IRQ, 22'h0);
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd1, SIG_IRQ, 22'h0);
	cpu_write(16'h5203, 8'h14);
	cpu_write(16'h5204, 8'h00); // Disabled, pending still visible
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd20, SIG_IRQ, 22'h0);
	ppu_step(14'h0000, 1'b0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd21, SIG_IRQ, 22'h0);
	cpu_check(16'h5204, 1'b0, SIG_PRG_RDATA, 22'hBF);
endtask

`endif

// File: dv/mmc5_tb.sv
// MMC5 core testbench; table driven, stops at the first mismatch, needs +incdir+dv for the vectors
`timescale 1ns/10ps

module mmc5_tb import mmc5_bus_pkg::*;;

	typedef enum logic [1:0] {OP_CPU_WR, OP_CPU_RD, OP_PPU, OP_CHECK} op_e;

	// Output compared by an entry
	typedef enum logic [3:0] {
		SIG_NONE, SIG_PRG_ADDR, SIG_PRG_ALLOW, SIG_PRG_RDATA,
		SIG_CHR_ADDR, SIG_CHR_ALLOW, SIG_CHR_RDATA, SIG_NT, SIG_IRQ
	} sig_e;

	typedef struct packed {
		op_e         op;
		logic        wr;         // CPU write level on checks, PPU write strobe on PPU steps
		logic [15:0] addr;       // CPU address
		logic [7:0]  data;       // CPU or PPU write data
		logic [13:0] paddr;      // PPU address
		logic        in_frame;
		logic        sprite16;
		logic [8:0]  cycle;
		logic [8:0]  scanline;
		sig_e        sig;
		logic [21:0] expect_val;
	} vec_t;

	logic        clk;
	logic        rst_n;
	cpu_bus_t    cpu;
	ppu_bus_t    ppu;
	logic [21:0] prg_addr, chr_addr;
	logic        prg_allow, chr_allow, chr_rdata_valid, vram_a10, vram_ce, irq;
	logic [7:0]  prg_rdata, chr_rdata;
	vec_t        vecs[$];    // Test table, filled at time 0
	logic        table_ready = 1'b0;

	mmc5_top mmc5_top_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.cpu             (cpu),
		.ppu             (ppu),
		.prg_addr        (prg_addr),
		.prg_allow       (prg_allow),
		.prg_rdata       (prg_rdata),
		.chr_addr        (chr_addr),
		.chr_allow       (chr_allow),
		.chr_rdata       (chr_rdata),
		.chr_rdata_valid (chr_rdata_valid),
		.vram_a10        (vram_a10),
		.vram_ce         (vram_ce),
		.irq             (irq)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// Table builders
	function automatic void cpu_write(input logic [15:0] addr, input logic [7:0] data);
		vec_t v;
		v      = '0;
		v.op   = OP_CPU_WR;
		v.addr = addr;
		v.data = data;
		vecs.push_back(v);
	endfunction

	function automatic void cpu_read(input logic [15:0] addr, input logic [7:0] exp);
		vec_t v;
		v            = '0;
		v.op         = OP_CPU_RD;
		v.addr       = addr;
		v.sig        = SIG_PRG_RDATA;
		v.expect_val = {14'd0, exp};
		vecs.push_back(v);
	endfunction

	function automatic void cpu_check(input logic [15:0] addr, input logic wr,
	                                  input sig_e sig, input logic [21:0] exp);
		vec_t v;
		v            = '0;
		v.op         = OP_CHECK;
		v.addr       = addr;
		v.wr         = wr;
		v.sig        = sig;
		v.expect_val = exp;
		vecs.push_back(v);
	endfunction

	function automatic void ppu_step(input logic [13:0] paddr, input logic wr,
	                                 input logic [7:0] wdata, input logic in_frame,
	                                 input logic sprite16, input logic [8:0] cycle,
	                                 input logic [8:0] scanline, input sig_e sig,
	                                 input logic [21:0] exp);
		vec_t v;
		v            = '0;
		v.op         = OP_PPU;
		v.paddr      = paddr;
		v.wr         = wr;
		v.data       = wdata;
		v.in_frame   = in_frame;
		v.sprite16   = sprite16;
		v.cycle      = cycle;
		v.scanline   = scanline;
		v.sig        = sig;
		v.expect_val = exp;
		vecs.push_back(v);
	endfunction

	`include "mmc5_tb_vectors.svh"

	task automatic check_value(input string name, input logic [21:0] got,
	                           input logic [21:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// One entry: a cycle with ce, then two quiet cycles, sampled on the falling edge
	task automatic apply_vector(input vec_t v);
		@(posedge clk);
		case (v.op)
			OP_CPU_WR: begin
				cpu.addr  <= v.addr;
				cpu.wdata <= v.data;
				cpu.write <= 1'b1;
				cpu.read  <= 1'b0;
				cpu.ce    <= 1'b1;
			end
			OP_CPU_RD: begin
				cpu.addr  <= v.addr;
				cpu.write <= 1'b0;
				cpu.read  <= 1'b1;
				cpu.ce    <= 1'b1;
			end
			OP_PPU: begin
				ppu.addr     <= v.paddr;
				ppu.wdata    <= v.data;
				ppu.write    <= v.wr;
				ppu.in_frame <= v.in_frame;
				ppu.sprite16 <= v.sprite16;
				ppu.cycle    <= v.cycle;
				ppu.scanline <= v.scanline;
				ppu.ce       <= 1'b1;
			end
			default: begin
				cpu.addr  <= v.addr; // No ce, so only the mappers see it
				cpu.write <= v.wr;
				cpu.read  <= 1'b0;
			end
		endcase
		@(posedge clk);
		cpu.ce    <= 1'b0;
		cpu.read  <= 1'b0;
		ppu.ce    <= 1'b0;
		ppu.write <= 1'b0;
		if (v.op == OP_CPU_WR)
			cpu.write <= 1'b0;
		@(posedge clk);
		@(negedge clk); // Outputs settled
		case (v.sig)
			SIG_PRG_ADDR:  check_value("prg_addr", prg_addr, v.expect_val);
			SIG_PRG_ALLOW: check_value("prg_allow", {21'd0, prg_allow}, v.expect_val);
			SIG_PRG_RDATA: check_value("prg_rdata", {14'd0, prg_rdata}, v.expect_val);
			SIG_CHR_ADDR:  check_value("chr_addr", chr_addr, v.expect_val);
			SIG_CHR_ALLOW: check_value("chr_allow", {21'd0, chr_allow}, v.expect_val);
			SIG_CHR_RDATA: check_value("chr_rdata", {14'd0, chr_rdata}, v.expect_val);
			SIG_NT: check_value("{chr_rdata_valid,vram_a10,vram_ce}",
			                    {19'd0, chr_rdata_valid, vram_a10, vram_ce}, v.expect_val);
			SIG_IRQ:       check_value("irq", {21'd0, irq}, v.expect_val);
			default: ;
		endcase
	endtask

	// Budget of 8 cycles per entry
	initial begin
		wait (table_ready);
		#(vecs.size() * 8 * 100);
		$display("Errors found");
		$fatal(1, "Timeout, the test table did not finish in time");
	end

	initial begin
		cpu   = '0;
		ppu   = '0;
		rst_n = 1'b0;
		load_vectors();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < vecs.size(); i++)
			apply_vector(vecs[i]);
		$display("No errors");
		$finish;
	end

endmodule

// File: hw/mmc5_bus_pkg.sv
// CPU and PPU bus bundles; strobes are only valid together with their ce, no back-pressure
package mmc5_bus_pkg;

	// CPU side, one strobe per M2 cycle
	typedef struct packed {
		logic        ce;    // CPU clock enable
		logic        read;
		logic        write;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} cpu_bus_t;

	// PPU side plus the frame state the mapper snoops
	typedef struct packed {
		logic        ce;       // PPU clock enable
		logic        read;
		logic        write;
		logic [13:0] addr;
		logic [7:0]  wdata;
		logic        in_frame; // Rendering active
		logic        sprite16; // 8x16 sprites enabled
		logic [8:0]  cycle;    // Dot within the line
		logic [8:0]  scanline;
	} ppu_bus_t;

	// ROM view of a PRG select word
	typedef struct packed {
		logic       is_rom;
		logic [6:0] bank;   // 8 KB ROM bank
	} prg_rom_sel_t;

	// RAM view, only eight save RAM banks
	typedef struct packed {
		logic       is_rom;
		logic [3:0] pad;
		logic [2:0] bank;
	} prg_ram_sel_t;

	// One select word, decoded by its top bit
	typedef union packed {
		prg_rom_sel_t rom;
		prg_ram_sel_t ram;
	} prg_sel_u;

endpackage

// File: hw/mmc5_chr_map.sv
// MMC5 CHR mapping; combinational, no split or ext attribute override, CHR region fixed at 2'b10
`timescale 1ns/10ps

module mmc5_chr_map import mmc5_reg_pkg::*, mmc5_bus_pkg::*; #(
	parameter logic CHR_WRITABLE = 1'b0
) (
	input  ppu_bus_t    ppu,
	input  mmc5_cfg_t   cfg,
	output logic [21:0] chr_addr,
	output logic        chr_allow
);

	localparam logic [1:0] CHR_REGION = 2'b10; // CHR sits above PRG

	logic      sprite_fetch; // Sprite pattern fetches of the line
	logic      chr_set;      // 0 is $5120-$5127, 1 is $5128-$512B
	logic [3:0] idx;
	chr_bank_t bank;
	logic [9:0] sel;         // 1 KB page

	assign sprite_fetch = (ppu.cycle >= 9'd256) && (ppu.cycle <= 9'd319);

	// 8x16 sprites split the sets by fetch type, else the set written last wins
	assign chr_set = (ppu.sprite16 && ppu.in_frame) ? !sprite_fetch : cfg.chr_last;

	always_comb begin
		// Which register serves this address
		case (cfg.chr_mode)
			2'd0: idx = chr_set ? 4'd11 : 4'd7;
			2'd1: idx = chr_set ? 4'd11 : {1'b0, ppu.addr[12], 2'b11};
			2'd2: idx = chr_set ? {2'b10, ppu.addr[11], 1'b1}
			                    : {1'b0, ppu.addr[12:11], 1'b1};
			default: idx = chr_set ? {2'b10, ppu.addr[11:10]} : {1'b0, ppu.addr[12:10]};
		endcase
		bank = cfg.chr_bank[idx];

		// Low page bits come from the address in the larger modes
		case (cfg.chr_mode)
			2'd0: sel = {bank[6:0], ppu.addr[12:10]}; // 8 KB
			2'd1: sel = {bank[7:0], ppu.addr[11:10]}; // 4 KB
			2'd2: sel = {bank[8:0], ppu.addr[10]};    // 2 KB
			default: sel = bank;                      // 1 KB
		endcase
	end

	assign chr_addr  = {CHR_REGION, sel, ppu.addr[9:0]};
	assign chr_allow = CHR_WRITABLE;

endmodule

// File: hw/mmc5_exram.sv
// MMC5 ExRAM and nametable routing; reads registered every clk, mode 1 acts as mode 0, no split
`timescale 1ns/10ps

module mmc5_exram import mmc5_reg_pkg::*, mmc5_bus_pkg::*; (
	input  logic       clk,
	input  cpu_bus_t   cpu,
	input  ppu_bus_t   ppu,
	input  mmc5_cfg_t  cfg,
	output logic [7:0] exram_rdata,
	output logic [7:0] chr_rdata,
	output logic       chr_rdata_valid,
	output logic       vram_a10,
	output logic       vram_ce
);

	logic [7:0] ram [1024];
	logic [7:0] ram_q;     // Registered read
	logic [7:0] last_vram; // Byte held for reads outside the frame
	logic [7:0] ex_byte;
	logic       last_read;
	logic       ram_mode;  // CPU owns the RAM
	logic       is_nt;     // $2000-$3FFF on the PPU
	logic [9:0] rd_addr;
	nt_src_e    src;

	assign ram_mode = cfg.exram_mode inside {RAM_RW, RAM_RO};
	assign is_nt    = ppu.addr[13];
	assign src      = cfg.mirroring[ppu.addr[11:10]]; // Quadrant source
	assign rd_addr  = ram_mode ? cpu.addr[9:0] : ppu.addr[9:0];

	always_ff @(posedge clk) begin
		if (cfg.exram_mode != RAM_RO) begin
			if (ppu.ce && ppu.write && !ppu.in_frame && !ram_mode && is_nt && src == EXRAM)
				ram[ppu.addr[9:0]] <= ppu.wdata;
			else if (cpu.ce && cpu.write && cpu.addr[15:10] == EXRAM_PAGE)
				// NT modes only take data while rendering
				ram[cpu.addr[9:0]] <= (cfg.exram_mode == RAM_RW || ppu.in_frame) ? cpu.wdata : 8'd0;
		end
		ram_q <= ram[rd_addr];
	end

	// Latch on the falling edge of the PPU read strobe
	always_ff @(posedge clk) begin
		last_read <= ppu.read;
		if (last_read && !ppu.read)
			last_vram <= ex_byte;
	end

	assign exram_rdata = ram_q;
	assign ex_byte     = ram_mode ? 8'd0 : ram_q;

	always_comb begin
		if (!ppu.in_frame)
			chr_rdata = last_vram;
		else if (src == FILL)
			chr_rdata = ppu.cycle[1] ? {4{cfg.fill_attr}} : cfg.fill_tile; // Attr vs name fetch
		else
			chr_rdata = ex_byte;
	end

	assign vram_a10        = src[0];
	assign vram_ce         = is_nt && !src[1]; // Internal 2 KB VRAM
	assign chr_rdata_valid = is_nt && src[1];  // ExRAM or fill supplies the byte

endmodule

// File: hw/mmc5_prg_map.sv
// MMC5 PRG mapping; purely combinational, save RAM limited to eight 8 KB banks at PRG_RAM_BASE
`timescale 1ns/10ps

module mmc5_prg_map import mmc5_reg_pkg::*, mmc5_bus_pkg::*; #(
	parameter logic [5:0] PRG_RAM_BASE = 6'b111100
) (
	input  cpu_bus_t    cpu,
	input  mmc5_cfg_t   cfg,
	output logic [21:0] prg_addr,
	output logic        prg_allow
);

	prg_sel_u sel;

	// Mode table, bank 3 always carries is_rom from the register
	always_comb begin
		if (!cpu.addr[15]) begin
			// $6000-$7FFF in every mode
			sel.ram.is_rom = 1'b0;
			sel.ram.pad    = '0;
			sel.ram.bank   = cfg.prg_ram_bank;
		end else begin
			case (cfg.prg_mode)
				2'd0: sel = {cfg.prg_bank[3][7:2], cpu.addr[14:13]}; // 32 KB
				2'd1: begin
					if (cpu.addr[14])
						sel = {cfg.prg_bank[3][7:1], cpu.addr[13]}; // 16 KB high
					else
						sel = {cfg.prg_bank[1][7:1], cpu.addr[13]}; // 16 KB low
				end
				2'd2: begin
					if (!cpu.addr[14])
						sel = {cfg.prg_bank[1][7:1], cpu.addr[13]};
					else if (!cpu.addr[13])
						sel = cfg.prg_bank[2]; // $C000
					else
						sel = cfg.prg_bank[3]; // $E000
				end
				default: sel = cfg.prg_bank[cpu.addr[14:13]]; // Four 8 KB windows
			endcase
		end
	end

	// ROM from 0, RAM in its own region
	assign prg_addr = sel.rom.is_rom ? {2'b00, sel.rom.bank, cpu.addr[12:0]}
	                                 : {PRG_RAM_BASE, sel.ram.bank, cpu.addr[12:0]};

	// Reads anywhere from $6000 up, writes only to unlocked RAM
	assign prg_allow = (cpu.addr >= 16'h6000) &&
	                   (!cpu.write || (!sel.rom.is_rom && cfg.prg_ram_we));

endmodule

// File: hw/mmc5_reg_pkg.sv
// MMC5 register map and decoded config; vertical split, ext attributes and audio registers absent
package mmc5_reg_pkg;

	// Page selectors on cpu.addr[15:10]
	localparam logic [5:0] REG_PAGE   = 6'b010100; // $5000-$53FF
	localparam logic [5:0] EXRAM_PAGE = 6'b010111; // $5C00-$5FFF

	// Offsets inside the register page
	localparam logic [9:0] REG_PRG_MODE      = 10'h100;
	localparam logic [9:0] REG_CHR_MODE      = 10'h101;
	localparam logic [9:0] REG_PROTECT_1     = 10'h102;
	localparam logic [9:0] REG_PROTECT_2     = 10'h103;
	localparam logic [9:0] REG_EXRAM_MODE    = 10'h104;
	localparam logic [9:0] REG_MIRRORING     = 10'h105;
	localparam logic [9:0] REG_FILL_TILE     = 10'h106;
	localparam logic [9:0] REG_FILL_ATTR     = 10'h107;
	localparam logic [9:0] REG_PRG_RAM_BANK  = 10'h113;
	localparam logic [9:0] REG_PRG_BANK_0    = 10'h114;
	localparam logic [9:0] REG_PRG_BANK_1    = 10'h115;
	localparam logic [9:0] REG_PRG_BANK_2    = 10'h116;
	localparam logic [9:0] REG_PRG_BANK_3    = 10'h117;
	localparam logic [9:0] REG_CHR_BANK_BASE = 10'h120; // 12 registers, $5120-$512B
	localparam logic [9:0] REG_CHR_UPPER     = 10'h130;
	localparam logic [9:0] REG_IRQ_LINE      = 10'h203;
	localparam logic [9:0] REG_IRQ_STATUS    = 10'h204; // Write sets enable, read clears pending
	localparam logic [9:0] REG_MUL_A         = 10'h205;
	localparam logic [9:0] REG_MUL_B         = 10'h206;

	// Unlock values for PRG RAM writes
	localparam logic [1:0] PROTECT_1_KEY = 2'b10;
	localparam logic [1:0] PROTECT_2_KEY = 2'b01;

	localparam logic [7:0] IRQ_LAST_LINE = 8'd239; // Last visible line

	// Per-quadrant nametable source, bit 1 set means the mapper supplies the byte
	typedef enum logic [1:0] {VRAM_A, VRAM_B, EXRAM, FILL} nt_src_e;

	typedef enum logic [1:0] {NT_0, NT_1, RAM_RW, RAM_RO} exram_mode_e;

	typedef logic [9:0] chr_bank_t; // {upper bits, written byte}

	typedef struct packed {
		logic [1:0]          prg_mode;
		logic [1:0]          chr_mode;
		logic                prg_ram_we;   // Both keys matched
		exram_mode_e         exram_mode;
		nt_src_e [3:0]       mirroring;    // Index is PPU addr[11:10]
		logic [7:0]          fill_tile;
		logic [1:0]          fill_attr;
		logic [2:0]          prg_ram_bank;
		logic [3:0][7:0]     prg_bank;     // Bit 7 set selects ROM
		chr_bank_t [11:0]    chr_bank;
		logic [1:0]          chr_upper;
		logic                chr_last;     // 1 when $5128-$512F written last
		logic [7:0]          irq_line;
		logic                irq_enable;
	} mmc5_cfg_t;

endpackage

// File: hw/mmc5_regs.sv
// MMC5 register file; writes land on cpu.ce edges, readback is combinational and open bus is 8'hFF
`timescale 1ns/10ps

module mmc5_regs import mmc5_reg_pkg::*, mmc5_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  cpu_bus_t   cpu,
	input  logic       irq_pending,
	input  logic       ppu_in_frame,
	input  logic [7:0] exram_rdata,  // Already one cycle behind the address
	output mmc5_cfg_t  cfg,
	output logic       status_read,
	output logic [7:0] prg_rdata
);

	logic        protect_1, protect_2; // Key match per protect register
	logic        key_1_ok, key_2_ok;
	logic        reg_wr;
	logic        chr_wr;               // Write somewhere in $5120-$512F
	logic [7:0]  mul_a, mul_b;
	logic [15:0] product;

	assign reg_wr   = cpu.ce && cpu.write && (cpu.addr[15:10] == REG_PAGE);
	assign chr_wr   = reg_wr && (cpu.addr[9:4] == REG_CHR_BANK_BASE[9:4]);
	assign key_1_ok = (cpu.wdata[1:0] == PROTECT_1_KEY);
	assign key_2_ok = (cpu.wdata[1:0] == PROTECT_2_KEY);
	assign product  = mul_a * mul_b; // Unsigned 8x8

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg             <= '0;
			cfg.prg_mode    <= 2'd3;  // 8 KB banks
			cfg.prg_bank[3] <= 8'hFF; // Last ROM bank at $E000
			protect_1       <= 1'b0;
			protect_2       <= 1'b0;
			mul_a           <= '0;
			mul_b           <= '0;
		end else begin
			if (reg_wr) begin
				case (cpu.addr[9:0])
					REG_PRG_MODE:   cfg.prg_mode <= cpu.wdata[1:0];
					REG_CHR_MODE:   cfg.chr_mode <= cpu.wdata[1:0];
					REG_PROTECT_1: begin
						protect_1      <= key_1_ok;
						cfg.prg_ram_we <= key_1_ok && protect_2; // Other key as stored
					end
					REG_PROTECT_2: begin
						protect_2      <= key_2_ok;
						cfg.prg_ram_we <= protect_1 && key_2_ok;
					end
					REG_EXRAM_MODE: cfg.exram_mode <= exram_mode_e'(cpu.wdata[1:0]);
					REG_MIRRORING: begin
						// Two bits per quadrant, quadrant 0 in the low bits
						for (int q = 0; q < 4; q++)
							cfg.mirroring[q] <= nt_src_e'(cpu.wdata[2*q +: 2]);
					end
					REG_FILL_TILE:    cfg.fill_tile    <= cpu.wdata;
					REG_FILL_ATTR:    cfg.fill_attr    <= cpu.wdata[1:0];
					REG_PRG_RAM_BANK: cfg.prg_ram_bank <= cpu.wdata[2:0];
					REG_PRG_BANK_0:   cfg.prg_bank[0]  <= cpu.wdata;
					REG_PRG_BANK_1:   cfg.prg_bank[1]  <= cpu.wdata;
					REG_PRG_BANK_2:   cfg.prg_bank[2]  <= cpu.wdata;
					REG_PRG_BANK_3:   cfg.prg_bank[3]  <= {1'b1, cpu.wdata[6:0]}; // ROM only
					REG_CHR_UPPER:    cfg.chr_upper    <= cpu.wdata[1:0];
					REG_IRQ_LINE:     cfg.irq_line     <= cpu.wdata;
					REG_IRQ_STATUS:   cfg.irq_enable   <= cpu.wdata[7];
					REG_MUL_A:        mul_a            <= cpu.wdata;
					REG_MUL_B:        mul_b            <= cpu.wdata;
					default: begin
						// CHR banks take the upper bits as they stand now
						if (chr_wr && cpu.addr[3:0] < 4'd12)
							cfg.chr_bank[cpu.addr[3:0]] <= {cfg.chr_upper, cpu.wdata};
					end
				endcase
			end
			if (chr_wr)
				cfg.chr_last <= cpu.addr[3]; // Set written last, $5128+ is set 1
		end
	end

	assign status_read = cpu.ce && cpu.read && (cpu.addr == {REG_PAGE, REG_IRQ_STATUS});

	always_comb begin
		prg_rdata = 8'hFF; // Open bus
		if (cpu.addr[15:10] == EXRAM_PAGE) begin
			if (cfg.exram_mode inside {RAM_RW, RAM_RO})
				prg_rdata = exram_rdata; // NT modes stay open bus
		end else if (cpu.addr == {REG_PAGE, REG_IRQ_STATUS}) begin
			prg_rdata = {irq_pending, ppu_in_frame, 6'b111111};
		end else if (cpu.addr == {REG_PAGE, REG_MUL_A}) begin
			prg_rdata = product[7:0];
		end else if (cpu.addr == {REG_PAGE, REG_MUL_B}) begin
			prg_rdata = product[15:8];
		end
	end

endmodule

// File: hw/mmc5_scanline_irq.sv
// MMC5 scanline IRQ; relies on the PPU scanline count, lines 1 to 239 only, no in-frame tracking
`timescale 1ns/10ps

module mmc5_scanline_irq import mmc5_reg_pkg::*, mmc5_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  ppu_bus_t  ppu,
	input  mmc5_cfg_t cfg,
	input  logic      status_read, // CPU read of $5204
	output logic      irq_pending,
	output logic      irq
);

	logic trig;     // Compare hit, one ppu.ce old
	logic last_lsb; // Scanline bit 0 at the previous ppu.ce

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_pending <= 1'b0;
			trig        <= 1'b0;
			last_lsb    <= 1'b0;
		end else begin
			if (ppu.ce) begin
				trig <= (cfg.irq_line != 8'd0) && (cfg.irq_line <= IRQ_LAST_LINE) &&
				        (ppu.scanline == {1'b0, cfg.irq_line});
				last_lsb <= ppu.scanline[0];
			end
			if (status_read)
				irq_pending <= 1'b0;
			// Next line after the match, takes priority over the clear
			if (ppu.ce && trig && (ppu.scanline[0] != last_lsb))
				irq_pending <= 1'b1;
		end
	end

	assign irq = irq_pending && cfg.irq_enable;

endmodule

// File: hw/mmc5_top.sv
// MMC5 banking core; no vertical split, no ext attribute mode, no audio, outputs always driven
`timescale 1ns/10ps

module mmc5_top import mmc5_reg_pkg::*, mmc5_bus_pkg::*; #(
	parameter logic [5:0] PRG_RAM_BASE = 6'b111100, // Save RAM region in PRG space
	parameter logic       CHR_WRITABLE = 1'b0       // Board has CHR RAM
) (
	input  logic        clk,
	input  logic        rst_n,
	input  cpu_bus_t    cpu,
	input  ppu_bus_t    ppu,
	output logic [21:0] prg_addr,
	output logic        prg_allow,
	output logic [7:0]  prg_rdata,
	output logic [21:0] chr_addr,
	output logic        chr_allow,
	output logic [7:0]  chr_rdata,
	output logic        chr_rdata_valid, // chr_rdata replaces the memory byte
	output logic        vram_a10,
	output logic        vram_ce,
	output logic        irq
);

	mmc5_cfg_t  cfg;
	logic       status_read; // $5204 read strobe
	logic       irq_pending;
	logic [7:0] exram_rdata;

	mmc5_regs mmc5_regs_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu          (cpu),
		.irq_pending  (irq_pending),
		.ppu_in_frame (ppu.in_frame),
		.exram_rdata  (exram_rdata),
		.cfg          (cfg),
		.status_read  (status_read),
		.prg_rdata    (prg_rdata)
	);

	mmc5_prg_map #(.PRG_RAM_BASE(PRG_RAM_BASE)) mmc5_prg_map_inst (
		.cpu       (cpu),
		.cfg       (cfg),
		.prg_addr  (prg_addr),
		.prg_allow (prg_allow)
	);

	mmc5_chr_map #(.CHR_WRITABLE(CHR_WRITABLE)) mmc5_chr_map_inst (
		.ppu       (ppu),
		.cfg       (cfg),
		.chr_addr  (chr_addr),
		.chr_allow (chr_allow)
	);

	mmc5_exram mmc5_exram_inst (
		.clk             (clk),
		.cpu             (cpu),
		.ppu             (ppu),
		.cfg             (cfg),
		.exram_rdata     (exram_rdata),
		.chr_rdata       (chr_rdata),
		.chr_rdata_valid (chr_rdata_valid),
		.vram_a10        (vram_a10),
		.vram_ce         (vram_ce)
	);

	mmc5_scanline_irq mmc5_scanline_irq_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ppu         (ppu),
		.cfg         (cfg),
		.status_read (status_read),
		.irq_pending (irq_pending),
		.irq         (irq)
	);

endmodule

// File: mmc5_top.f
+incdir+dv
hw/mmc5_reg_pkg.sv
hw/mmc5_bus_pkg.sv
hw/mmc5_regs.sv
hw/mmc5_prg_map.sv
hw/mmc5_chr_map.sv
hw/mmc5_exram.sv
hw/mmc5_scanline_irq.sv
hw/mmc5_top.sv
dv/mmc5_tb.sv
